// File: verilog.f
hw/rv_mem_pkg.sv
hw/rv_pipe_pkg.sv
hw/ex_mem_register.sv
hw/mem_access_unit.sv
hw/mem_wb_register.sv
hw/writeback_stage.sv
hw/backend_top.sv
verif/apb_mem_model.sv
verif/tb_backend_top.sv

// File: run.sh
#!/bin/sh
# Compile with Verilator, run, and judge the run from its log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_backend_top \
    -f verilog.f -o sim_backend \
    && ./obj_dir/sim_backend > sim.log 2>&1 \
    || { echo "Build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || exit 1
exit 0

// File: verif/tb_backend_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_backend_top;

    localparam int ADDR_W  = 12;
    localparam int TIMEOUT = 100;

    logic                 clk;
    logic                 reset;
    logic                 flush;
    logic                 in_valid;
    rv_pipe_pkg::ex_mem_t in_instr;
    logic                 in_ready;
    rv_mem_pkg::apb_req_t apb_req;
    logic                 psel;
    logic                 penable;
    logic [31:0]          prdata;
    logic                 pready;
    logic [4:0]           dbg_addr;
    logic [31:0]          dbg_data;

    logic [31:0]          ref_regs [32];
    logic [7:0]           ref_mem [2**ADDR_W];
    rv_mem_pkg::apb_req_t exp_req_q [$];
    rv_mem_pkg::apb_req_t setup_req;
    rv_mem_pkg::mem_size_e size_list [5];
    int                   errors;
    int                   seed;
    int                   cnt;
    int                   k;
    logic                 drain_ok;   // A flushed transfer may finish with in_ready high.

    backend_top #(.NUM_REGS(32), .ADDR_W(ADDR_W)) u_backend_top (
        .clk(clk), .reset(reset), .flush(flush), .in_valid(in_valid), .in_instr(in_instr),
        .in_ready(in_ready), .apb_req(apb_req), .psel(psel), .penable(penable),
        .prdata(prdata), .pready(pready), .dbg_addr(dbg_addr), .dbg_data(dbg_data)
    );

    apb_mem_model #(.ADDR_W(ADDR_W)) u_mem (
        .clk(clk), .reset(reset), .apb_req(apb_req), .psel(psel), .penable(penable),
        .prdata(prdata), .pready(pready)
    );

    always #50 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR at %0t: %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("ERROR at %0t: timed out waiting for %s", $time, what);
        $display("Errors: %0d", errors + 1);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    function automatic rv_pipe_pkg::ex_mem_t make_instr(input rv_pipe_pkg::wb_sel_e sel,
            input rv_mem_pkg::mem_size_e size, input logic [4:0] rd, input logic [31:0] addr,
            input logic mr, input logic mw);
        rv_pipe_pkg::ex_mem_t ins;
        ins.pc_plus_4     = $random(seed);
        ins.imm           = $random(seed);
        ins.csr_read_data = $random(seed);
        ins.store_data    = $random(seed);
        ins.alu_result    = addr;
        ins.wb_sel        = sel;
        ins.mem_size      = size;
        ins.mem_read      = mr;
        ins.mem_write     = mw;
        ins.reg_write     = !mw;
        ins.rd            = rd;
        return ins;
    endfunction

    // Called on a falling edge; returns on the falling edge after the transfer.
    task automatic send(input rv_pipe_pkg::ex_mem_t ins, input bit commit);
        rv_mem_pkg::apb_req_t req;
        logic [ADDR_W-1:0]    a;
        logic [31:0]          word;
        logic [31:0]          lane;
        logic [31:0]          value;
        logic [1:0]           off;
        int                   waited;
        int                   nbytes;
        in_valid = 1'b1;
        in_instr = ins;
        waited   = 0;
        while (!in_ready) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) stop_on_timeout("in_ready");
        end
        @(negedge clk);
        in_valid = 1'b0;
        off  = ins.alu_result[1:0];
        a    = {ins.alu_result[ADDR_W-1:2], 2'b00};
        word = {ref_mem[a + ADDR_W'(3)], ref_mem[a + ADDR_W'(2)],
                ref_mem[a + ADDR_W'(1)], ref_mem[a]};
        req  = '0;
        req.paddr[ADDR_W-1:0] = ins.alu_result[ADDR_W-1:0];
        if (ins.mem_write) begin
            req.pwrite = 1'b1;
            case (ins.mem_size)
                rv_mem_pkg::size_b, rv_mem_pkg::size_bu: nbytes = 1;
                rv_mem_pkg::size_h, rv_mem_pkg::size_hu: nbytes = 2;
                default:                                 nbytes = 4;
            endcase
            // Byte i of the store data lands on lane off + i.
            for (int b = 0; b < 4; b++) begin
                if (b >= int'(off) && b < int'(off) + nbytes) begin
                    req.pstrb[b]            = 1'b1;
                    req.pwdata[8*b +: 8]    = ins.store_data[8*(b - int'(off)) +: 8];
                    ref_mem[a + ADDR_W'(b)] = ins.store_data[8*(b - int'(off)) +: 8];
                end
            end
        end
        if (ins.mem_read || ins.mem_write) exp_req_q.push_back(req);
        lane = word >> (8 * off);
        case (ins.wb_sel)
            rv_pipe_pkg::wb_load: begin
                case (ins.mem_size)
                    rv_mem_pkg::size_b:  value = {{24{lane[7]}}, lane[7:0]};
                    rv_mem_pkg::size_bu: value = {24'b0, lane[7:0]};
                    rv_mem_pkg::size_h:  value = {{16{lane[15]}}, lane[15:0]};
                    rv_mem_pkg::size_hu: value = {16'b0, lane[15:0]};
                    default:             value = word;
                endcase
            end
            rv_pipe_pkg::wb_pc_plus_4: value = ins.pc_plus_4;
            rv_pipe_pkg::wb_imm:       value = ins.imm;
            rv_pipe_pkg::wb_csr:       value = ins.csr_read_data;
            default:                   value = ins.alu_result;
        endcase
        if (commit && ins.reg_write && ins.rd != 5'd0) ref_regs[ins.rd] = value;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (!(in_ready && !psel)) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) stop_on_timeout("the pipeline to drain");
        end
        repeat (3) @(negedge clk); // Last instruction reaches the register file.
    endtask

    task automatic check_regs();
        for (int r = 0; r < 32; r++) begin
            @(negedge clk);
            dbg_addr = 5'(r);
            #10;
            check_value($sformatf("dbg_data(x%0d)", r), dbg_data, ref_regs[r]);
        end
        @(negedge clk);
    endtask

    // Bus monitor: requests against the model, and stability through the transfer.
    always @(negedge clk) begin
        if (!reset && psel && !penable) begin
            assert (!in_ready) else begin
                $display("ERROR at %0t: in_ready high during APB setup", $time);
                errors++;
            end
            if (exp_req_q.size() == 0) begin
                $display("ERROR at %0t: APB transfer started with none expected", $time);
                errors++;
            end else begin
                check_value("paddr", apb_req.paddr, exp_req_q[0].paddr);
                check_value("pwrite", 32'(apb_req.pwrite), 32'(exp_req_q[0].pwrite));
                check_value("pwdata", apb_req.pwdata, exp_req_q[0].pwdata);
                check_value("pstrb", 32'(apb_req.pstrb), 32'(exp_req_q[0].pstrb));
                void'(exp_req_q.pop_front());
            end
            setup_req = apb_req;
        end else if (!reset && psel && penable) begin
            assert (apb_req === setup_req) else begin
                $display("ERROR at %0t: apb_req changed before the transfer completed", $time);
                errors++;
            end
            assert (pready || drain_ok || !in_ready) else begin
                $display("ERROR at %0t: in_ready high during an APB wait state", $time);
                errors++;
            end
        end
    end

    initial begin
        clk      = 1'b0;
        reset    = 1'b1;
        flush    = 1'b0;
        in_valid = 1'b0;
        in_instr = '0;
        dbg_addr = 5'd0;
        drain_ok = 1'b0;
        errors   = 0;
        seed     = 35;
        size_list = '{rv_mem_pkg::size_b, rv_mem_pkg::size_h, rv_mem_pkg::size_w,
                      rv_mem_pkg::size_bu, rv_mem_pkg::size_hu};
        for (int r = 0; r < 32; r++) ref_regs[r] = 32'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int a = 0; a < 2**ADDR_W; a++) ref_mem[a] = u_mem.mem[ADDR_W'(a)];

        check_value("psel", 32'(psel), 32'd0);
        check_value("penable", 32'(penable), 32'd0);
        check_value("in_ready", 32'(in_ready), 32'd1);
        check_regs();

        // Every write-back source, then a write to x0. The load source needs a real read.
        for (int s = 0; s < 5; s++) begin
            send(make_instr(rv_pipe_pkg::wb_sel_e'(3'(s)), rv_mem_pkg::size_w, 5'(s + 1),
                 $random(seed) & 32'hffff_fffc, s == 1, 1'b0), 1'b1);
        end
        send(make_instr(rv_pipe_pkg::wb_alu, rv_mem_pkg::size_w, 5'd0, 32'hdead_beef,
             1'b0, 1'b0), 1'b1);
        wait_drain();
        check_regs();

        // Stores at each lane, then loads of every size from them.
        for (int o = 0; o < 4; o++) begin
            send(make_instr(rv_pipe_pkg::wb_alu, rv_mem_pkg::size_b, 5'd0, 32'h100 + o,
                 1'b0, 1'b1), 1'b1);
        end
        send(make_instr(rv_pipe_pkg::wb_alu, rv_mem_pkg::size_h, 5'd0, 32'h104, 1'b0, 1'b1), 1'b1);
        send(make_instr(rv_pipe_pkg::wb_alu, rv_mem_pkg::size_h, 5'd0, 32'h106, 1'b0, 1'b1), 1'b1);
        send(make_instr(rv_pipe_pkg::wb_alu, rv_mem_pkg::size_w, 5'd0, 32'h108, 1'b0, 1'b1), 1'b1);
        for (int o = 0; o < 4; o++) begin
            send(make_instr(rv_pipe_pkg::wb_load, rv_mem_pkg::size_b, 5'(o + 8), 32'h100 + o,
                 1'b1, 1'b0), 1'b1);
            send(make_instr(rv_pipe_pkg::wb_load, rv_mem_pkg::size_bu, 5'(o + 12), 32'h100 + o,
                 1'b1, 1'b0), 1'b1);
        end
        for (int o = 0; o < 4; o += 2) begin
            send(make_instr(rv_pipe_pkg::wb_load, rv_mem_pkg::size_h, 5'(o + 16), 32'h104 + o,
                 1'b1, 1'b0), 1'b1);
            send(make_instr(rv_pipe_pkg::wb_load, rv_mem_pkg::size_hu, 5'(o + 17), 32'h104 + o,
                 1'b1, 1'b0), 1'b1);
        end
        send(make_instr(rv_pipe_pkg::wb_load, rv_mem_pkg::size_w, 5'd20, 32'h108, 1'b1, 1'b0), 1'b1);
        wait_drain();
        check_regs();

        // Random mix under random wait states.
        for (int n = 0; n < 40; n++) begin
            k = $unsigned($random(seed)) % 5;
            cnt = $unsigned($random(seed)) % 3;
            if (cnt == 0) begin
                send(make_instr(rv_pipe_pkg::wb_sel_e'(3'(k == 1 ? 0 : k)), rv_mem_pkg::size_w,
                     5'($random(seed)), $random(seed), 1'b0, 1'b0), 1'b1);
            end else begin
                send(make_instr(cnt == 1 ? rv_pipe_pkg::wb_alu : rv_pipe_pkg::wb_load,
                     size_list[k], 5'($random(seed)),
                     32'h200 + ($unsigned($random(seed)) % 64) * 4
                     + (k % 3 == 0 ? $unsigned($random(seed)) % 4 : (k % 3 == 1 ? 2 : 0)),
                     cnt == 2, cnt == 1), 1'b1);
            end
        end
        wait_drain();
        check_regs();

        // Flush an instruction in EX/MEM, then a load in its access phase.
        send(make_instr(rv_pipe_pkg::wb_imm, rv_mem_pkg::size_w, 5'd5, 32'h0, 1'b0, 1'b0), 1'b0);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        send(make_instr(rv_pipe_pkg::wb_load, rv_mem_pkg::size_w, 5'd6, 32'h100, 1'b1, 1'b0), 1'b0);
        cnt = 0;
        while (!(psel && penable)) begin
            @(negedge clk);
            cnt++;
            if (cnt > TIMEOUT) stop_on_timeout("the APB access phase");
        end
        drain_ok = 1'b1;
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        wait_drain();
        drain_ok = 1'b0;
        send(make_instr(rv_pipe_pkg::wb_csr, rv_mem_pkg::size_w, 5'd7, 32'h0, 1'b0, 1'b0), 1'b1);
        send(make_instr(rv_pipe_pkg::wb_load, rv_mem_pkg::size_hu, 5'd21, 32'h106, 1'b1, 1'b0),
             1'b1);
        wait_drain();
        check_regs();

        for (int a = 0; a < 2**ADDR_W; a++) begin
            check_value($sformatf("mem[%0h]", a), 32'(u_mem.mem[ADDR_W'(a)]),
                        32'(ref_mem[ADDR_W'(a)]));
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/apb_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module apb_mem_model #(
    parameter int ADDR_W = 12
) (
    input  logic                 clk,
    input  logic                 reset,
    input  rv_mem_pkg::apb_req_t apb_req,
    input  logic                 psel,
    input  logic                 penable,
    output logic [31:0]          prdata,
    output logic                 pready
);

    logic [7:0]        mem [2**ADDR_W];
    logic [ADDR_W-1:0] base;
    logic [1:0]        wait_cnt;
    int                seed;

    initial begin
        seed = 35;
        for (int i = 0; i < 2**ADDR_W; i++) begin
            mem[i] = 8'(i * 37 + (i >> 8) * 11); // Every address bit matters.
        end
    end

    assign base   = {apb_req.paddr[ADDR_W-1:2], 2'b00};
    assign pready = psel && penable && (wait_cnt == 2'd0);
    assign prdata = {mem[base + ADDR_W'(3)], mem[base + ADDR_W'(2)],
                     mem[base + ADDR_W'(1)], mem[base]};

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            wait_cnt <= 2'd0;
        end else if (psel && !penable) begin
            wait_cnt <= 2'($random(seed)); // 0 to 3 wait states.
        end else if (psel && penable) begin
            if (wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 2'd1;
            end else if (apb_req.pwrite) begin
                for (int b = 0; b < 4; b++) begin
                    if (apb_req.pstrb[b]) mem[base + ADDR_W'(b)] <= apb_req.pwdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/backend_top.sv
`timescale 1ns/1ns
`default_nettype none

module backend_top #(
    parameter int NUM_REGS = 32,
    parameter int ADDR_W   = 12
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  logic                 in_valid,
    input  rv_pipe_pkg::ex_mem_t in_instr,
    output logic                 in_ready,
    output rv_mem_pkg::apb_req_t apb_req,
    output logic                 psel,
    output logic                 penable,
    input  logic [31:0]          prdata,
    input  logic                 pready,
    input  logic [4:0]           dbg_addr,
    output logic [31:0]          dbg_data
);

    logic                 mem_valid;
    rv_pipe_pkg::ex_mem_t mem_instr;
    logic                 mem_done;
    rv_pipe_pkg::mem_wb_t wb_next;
    logic                 wb_valid;
    rv_pipe_pkg::mem_wb_t wb_instr;
    logic                 stall;

    // Hold EX/MEM while its instruction cannot advance.
    assign stall    = mem_valid && !mem_done;
    assign in_ready = !stall;

    ex_mem_register u_ex_mem_register (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_instr  (in_instr),
        .stall     (stall),
        .mem_valid (mem_valid),
        .mem_instr (mem_instr)
    );

    mem_access_unit #(
        .ADDR_W (ADDR_W)
    ) u_mem_access_unit (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .mem_valid (mem_valid),
        .mem_instr (mem_instr),
        .mem_done  (mem_done),
        .wb_next   (wb_next),
        .apb_req   (apb_req),
        .psel      (psel),
        .penable   (penable),
        .prdata    (prdata),
        .pready    (pready)
    );

    mem_wb_register u_mem_wb_register (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .mem_done (mem_done),
        .wb_next  (wb_next),
        .wb_valid (wb_valid),
        .wb_instr (wb_instr)
    );

    writeback_stage #(
        .NUM_REGS (NUM_REGS)
    ) u_writeback_stage (
        .clk      (clk),
        .reset    (reset),
        .wb_valid (wb_valid),
        .wb_instr (wb_instr),
        .dbg_addr (dbg_addr),
        .dbg_data (dbg_data)
    );

endmodule

`default_nettype wire

// File: hw/writeback_stage.sv
`timescale 1ns/1ns
`default_nettype none

module writeback_stage #(
    parameter int NUM_REGS = 32
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 wb_valid,
    input  rv_pipe_pkg::mem_wb_t wb_instr,
    input  logic [4:0]           dbg_addr,
    output logic [31:0]          dbg_data
);

    logic [31:0] regs [NUM_REGS];
    logic [31:0] wr_data;
    logic        wr_en;

    always_comb begin
        case (wb_instr.wb_sel)
            rv_pipe_pkg::wb_load:      wr_data = wb_instr.load_data;
            rv_pipe_pkg::wb_pc_plus_4: wr_data = wb_instr.pc_plus_4;
            rv_pipe_pkg::wb_imm:       wr_data = wb_instr.imm;
            rv_pipe_pkg::wb_csr:       wr_data = wb_instr.csr_read_data;
            default:                   wr_data = wb_instr.alu_result;
        endcase
    end

    assign wr_en = wb_valid && wb_instr.reg_write && (wb_instr.rd != 5'd0) &&
                   (int'(wb_instr.rd) < NUM_REGS); // x0 stays zero.

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= 32'b0;
            end
        end else if (wr_en) begin
            regs[wb_instr.rd] <= wr_data;
        end
    end

    // Debug read, combinational.
    assign dbg_data = (int'(dbg_addr) < NUM_REGS) ? regs[dbg_addr] : 32'b0;

endmodule

`default_nettype wire

// File: hw/mem_wb_register.sv
`timescale 1ns/1ns
`default_nettype none

module mem_wb_register (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  logic                 mem_done,
    input  rv_pipe_pkg::mem_wb_t wb_next,
    output logic                 wb_valid,
    output rv_pipe_pkg::mem_wb_t wb_instr
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_valid <= 1'b0;
            wb_instr <= '0;
        end else if (flush) begin
            wb_valid <= 1'b0;
            wb_instr <= '0;
        end else begin
            // A stalled MEM stage leaves a bubble here.
            wb_valid <= mem_done;
            wb_instr <= wb_next;
        end
    end

endmodule

`default_nettype wire

// File: hw/mem_access_unit.sv
`timescale 1ns/1ns
`default_nettype none

module mem_access_unit #(
    parameter int ADDR_W = 12
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  logic                  mem_valid,
    input  rv_pipe_pkg::ex_mem_t  mem_instr,
    output logic                  mem_done,
    output rv_pipe_pkg::mem_wb_t  wb_next,
    output rv_mem_pkg::apb_req_t  apb_req,
    output logic                  psel,
    output logic                  penable,
    input  logic [31:0]           prdata,
    input  logic                  pready
);

    typedef enum logic [1:0] {
        idle,
        setup,
        access,
        drain     // Flushed transfer still waiting on pready.
    } state_e;

    state_e state;
    state_e state_next;

    logic                                is_mem;
    logic                                start;
    logic [1:0]                          byte_off;
    logic [1:0]                          rd_off;
    logic [31:0]                         store_wdata;
    logic [3:0]                          store_strb;
    logic [rv_mem_pkg::ADDR_MAX-1:0]     next_paddr;
    logic [31:0]                         load_lane;
    logic [31:0]                         load_ext;

    assign is_mem   = mem_instr.mem_read | mem_instr.mem_write;
    assign start    = (state == idle) && (state_next == setup);
    assign mem_done = mem_valid && (!is_mem || ((state == access) && pready));

    assign psel    = (state != idle);
    assign penable = (state == access) || (state == drain);

    always_comb begin
        state_next = state;
        case (state)
            idle:    if (mem_valid && is_mem && !flush) state_next = setup;
            setup:   state_next = flush ? drain : access; // Setup always leads to an access phase.
            access:  begin
                if (pready) state_next = idle;
                else if (flush) state_next = drain;
            end
            drain:   if (pready) state_next = idle;
            default: state_next = idle;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

    // Store lanes and strobes.
    always_comb begin
        byte_off   = mem_instr.alu_result[1:0];
        next_paddr = '0;
        next_paddr[ADDR_W-1:0] = mem_instr.alu_result[ADDR_W-1:0];
        case (mem_instr.mem_size)
            rv_mem_pkg::size_b, rv_mem_pkg::size_bu: begin
                store_wdata = {24'b0, mem_instr.store_data[7:0]} << {byte_off, 3'b000};
                store_strb  = 4'b0001 << byte_off;
            end
            rv_mem_pkg::size_h, rv_mem_pkg::size_hu: begin
                store_wdata = {16'b0, mem_instr.store_data[15:0]} << {byte_off[1], 4'b0000};
                store_strb  = byte_off[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                store_wdata = mem_instr.store_data;
                store_strb  = 4'b1111;
            end
        endcase
    end

    // Request is captured once and held until the transfer ends.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            apb_req <= '0;
        end else if (start) begin
            apb_req.paddr  <= next_paddr;
            apb_req.pwrite <= mem_instr.mem_write;
            apb_req.pwdata <= mem_instr.mem_write ? store_wdata : 32'b0;
            apb_req.pstrb  <= mem_instr.mem_write ? store_strb : 4'b0000;
        end
    end

    // Load extraction and extension.
    always_comb begin
        rd_off    = apb_req.paddr[1:0];
        load_lane = prdata >> {rd_off, 3'b000};
        case (mem_instr.mem_size)
            rv_mem_pkg::size_b:  load_ext = {{24{load_lane[7]}}, load_lane[7:0]};
            rv_mem_pkg::size_bu: load_ext = {24'b0, load_lane[7:0]};
            rv_mem_pkg::size_h:  load_ext = {{16{load_lane[15]}}, load_lane[15:0]};
            rv_mem_pkg::size_hu: load_ext = {16'b0, load_lane[15:0]};
            default:             load_ext = prdata;
        endcase
    end

    always_comb begin
        wb_next.pc_plus_4     = mem_instr.pc_plus_4;
        wb_next.imm           = mem_instr.imm;
        wb_next.csr_read_data = mem_instr.csr_read_data;
        wb_next.alu_result    = mem_instr.alu_result;
        wb_next.load_data     = load_ext;
        wb_next.wb_sel        = mem_instr.wb_sel;
        wb_next.reg_write     = mem_instr.reg_write;
        wb_next.rd            = mem_instr.rd;
    end

endmodule

`default_nettype wire

// File: hw/ex_mem_register.sv
`timescale 1ns/1ns
`default_nettype none

module ex_mem_register (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  logic                 in_valid,
    input  rv_pipe_pkg::ex_mem_t in_instr,
    input  logic                 stall,
    output logic                 mem_valid,
    output rv_pipe_pkg::ex_mem_t mem_instr
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_valid <= 1'b0;
            mem_instr <= '0;
        end else if (flush) begin
            // Kill the instruction but leave its payload in place.
            mem_valid           <= 1'b0;
            mem_instr.mem_read  <= 1'b0;
            mem_instr.mem_write <= 1'b0;
            mem_instr.reg_write <= 1'b0;
        end else if (!stall) begin
            mem_valid <= in_valid;
            mem_instr <= in_instr;
        end
    end

endmodule

`default_nettype wire

// File: hw/rv_pipe_pkg.sv
`default_nettype none

package rv_pipe_pkg;

    // Source of the register file write value.
    typedef enum logic [2:0] {
        wb_alu       = 3'd0,
        wb_load      = 3'd1,
        wb_pc_plus_4 = 3'd2,
        wb_imm       = 3'd3,
        wb_csr       = 3'd4
    } wb_sel_e;

    // Instruction leaving EX.
    typedef struct packed {
        logic [31:0]           pc_plus_4;
        logic [31:0]           imm;
        logic [31:0]           csr_read_data;
        logic [31:0]           alu_result;   // Also the memory address.
        logic [31:0]           store_data;
        wb_sel_e               wb_sel;
        rv_mem_pkg::mem_size_e mem_size;
        logic                  mem_read;
        logic                  mem_write;
        logic                  reg_write;
        logic [4:0]            rd;
    } ex_mem_t;

    // Instruction leaving MEM.
    typedef struct packed {
        logic [31:0] pc_plus_4;
        logic [31:0] imm;
        logic [31:0] csr_read_data;
        logic [31:0] alu_result;
        logic [31:0] load_data;
        wb_sel_e     wb_sel;
        logic        reg_write;
        logic [4:0]  rd;
    } mem_wb_t;

endpackage

`default_nettype wire

// File: hw/rv_mem_pkg.sv
`default_nettype none

package rv_mem_pkg;

    // Widest address the APB request can carry.
    localparam int ADDR_MAX = 32;

    // Load/store size, as coded in funct3.
    typedef enum logic [2:0] {
        size_b  = 3'b000,
        size_h  = 3'b001,
        size_w  = 3'b010,
        size_bu = 3'b100,
        size_hu = 3'b101
    } mem_size_e;

    // Request fields held on the bus from setup to completion.
    typedef struct packed {
        logic [ADDR_MAX-1:0] paddr; // Upper bits above ADDR_W are zero.
        logic                pwrite;
        logic [31:0]         pwdata;
        logic [3:0]          pstrb;
    } apb_req_t;

endpackage

`default_nettype wire
